/* build.f */
+incdir+verification
source/mips_pkg.sv
source/alu.sv
source/regfile.sv
source/pipe_reg.sv
source/control_decoder.sv
source/hazard_unit.sv
source/datapath.sv
source/mips_core.sv
verification/tb_mips.sv

/* run.sh */
#!/bin/sh
# compile with verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f build.f --top-module tb_mips -o tb_mips_sim &&
./obj_dir/tb_mips_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }

/* source/alu.sv */
`timescale 1ns/1ps

// 32 bit integer alu
module alu (
  input  mips_pkg::word_t     a,
  input  mips_pkg::word_t     b,
  input  mips_pkg::alu_ctrl_t op,
  output mips_pkg::word_t     result,
  output logic                zero     // used by beq and bne
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb
  begin
    case (op)
      mips_pkg::alu_and:  result = a & b;
      mips_pkg::alu_or:   result = a | b;
      mips_pkg::alu_add:  result = a + b;             // add, addu, lw, sw, lui
      mips_pkg::alu_sub:  result = a - b;
      mips_pkg::alu_slt:  result = {31'b0, lt_signed};
      mips_pkg::alu_sltu: result = {31'b0, lt_unsigned};
      default:            result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* source/control_decoder.sv */
`timescale 1ns/1ps

// instruction to control struct
// main decoder on opcode, alu decoder on funct for r-type
module control_decoder (
  input  mips_pkg::word_t instr,
  output mips_pkg::ctrl_t ctrl
);

  logic [5:0]           op;
  logic [5:0]           funct;
  mips_pkg::alu_ctrl_t  funct_op;   // alu op picked by funct

  assign op    = instr[31:26];
  assign funct = instr[5:0];

  // --------------------
  // alu decoder
  always_comb
  begin
    case (funct)
      mips_pkg::fn_add,
      mips_pkg::fn_addu: funct_op = mips_pkg::alu_add;
      mips_pkg::fn_sub,
      mips_pkg::fn_subu: funct_op = mips_pkg::alu_sub;
      mips_pkg::fn_and:  funct_op = mips_pkg::alu_and;
      mips_pkg::fn_or:   funct_op = mips_pkg::alu_or;
      mips_pkg::fn_slt:  funct_op = mips_pkg::alu_slt;
      mips_pkg::fn_sltu: funct_op = mips_pkg::alu_sltu;
      default:           funct_op = mips_pkg::alu_add;  // nop ends up writing r0
    endcase
  end

  // --------------------
  // main decoder
  always_comb
  begin
    ctrl = '0;                                   // unknown opcodes give a bubble
    case (op)
      mips_pkg::op_rtype:
      begin
        ctrl.regdst     = 1'b1;
        ctrl.regwrite   = 1'b1;
        ctrl.alucontrol = funct_op;
      end
      mips_pkg::op_lw:
      begin
        ctrl.signext    = 1'b1;
        ctrl.alusrc     = 1'b1;                  // base plus offset
        ctrl.memread    = 1'b1;
        ctrl.memtoreg   = 1'b1;
        ctrl.regwrite   = 1'b1;
        ctrl.alucontrol = mips_pkg::alu_add;
      end
      mips_pkg::op_sw:
      begin
        ctrl.signext    = 1'b1;
        ctrl.alusrc     = 1'b1;
        ctrl.memwrite   = 1'b1;
        ctrl.alucontrol = mips_pkg::alu_add;
      end
      mips_pkg::op_beq,
      mips_pkg::op_bne:
      begin
        ctrl.signext    = 1'b1;                  // word offset, signed
        ctrl.branch     = (op == mips_pkg::op_beq);
        ctrl.bnebeq     = (op == mips_pkg::op_bne);
        ctrl.alucontrol = mips_pkg::alu_sub;     // zero flag compares rs and rt
      end
      mips_pkg::op_addi,
      mips_pkg::op_addiu,
      mips_pkg::op_slti:
      begin
        ctrl.signext    = 1'b1;
        ctrl.alusrc     = 1'b1;
        ctrl.regwrite   = 1'b1;
        ctrl.alucontrol = (op == mips_pkg::op_slti) ? mips_pkg::alu_slt : mips_pkg::alu_add;
      end
      mips_pkg::op_ori,
      mips_pkg::op_lui:
      begin
        ctrl.shiftl16   = (op == mips_pkg::op_lui);  // zero extended in both cases
        ctrl.alusrc     = 1'b1;
        ctrl.regwrite   = 1'b1;
        ctrl.alucontrol = (op == mips_pkg::op_ori) ? mips_pkg::alu_or : mips_pkg::alu_add;
      end
      mips_pkg::op_j:    ctrl.jump = 1'b1;
      default:
      begin
      end
    endcase
  end

endmodule

/* source/datapath.sv */
`timescale 1ns/1ps

// pc, stage registers and the per stage logic
module datapath (
  input  logic            clk,
  input  logic            reset,
  output mips_pkg::word_t pc,
  input  mips_pkg::word_t instr,
  output logic            mem_write,
  output mips_pkg::word_t mem_addr,
  output mips_pkg::word_t mem_wdata,
  input  mips_pkg::word_t mem_rdata
);

  mips_pkg::ifid_t    ifid_d, ifid_q;
  mips_pkg::idex_t    idex_d, idex_q;
  mips_pkg::exmem_t   exmem_d, exmem_q;
  mips_pkg::memwb_t   memwb_d, memwb_q;
  mips_pkg::ctrl_t    dec_ctrl;
  mips_pkg::word_t    pcplus4, branch_target, jump_target, pc_target;
  mips_pkg::word_t    rf_rd1, rf_rd2, dec_imm;
  mips_pkg::word_t    ex_a_fwd, ex_b_fwd, ex_imm, alu_a, alu_b, alu_result;
  mips_pkg::word_t    wb_result;
  mips_pkg::fwd_sel_t fwd_ex_a, fwd_ex_b;
  logic               stall, flush, fwd_dec_a, fwd_dec_b;
  logic               alu_zero, redirect;

  // --------------------
  // fetch
  assign pcplus4 = pc + mips_pkg::pc_step;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= '0;
    else if (flush)
      pc <= pc_target;       // redirect beats a stall
    else if (!stall)
      pc <= pcplus4;
  end

  assign ifid_d = '{instr: instr, pcplus4: pcplus4};

  pipe_reg #(.payload_t(mips_pkg::ifid_t)) u_ifid (
    .clk (clk), .reset (reset), .en (!stall), .clear (flush), .d (ifid_d), .q (ifid_q)
  );

  // --------------------
  // decode
  control_decoder u_dec (.instr (ifid_q.instr), .ctrl (dec_ctrl));

  regfile u_rf (
    .clk (clk), .we (memwb_q.regwrite), .wa (memwb_q.wreg), .wd (wb_result),
    .ra1 (ifid_q.instr[25:21]), .ra2 (ifid_q.instr[20:16]), .rd1 (rf_rd1), .rd2 (rf_rd2)
  );

  // sign or zero extension, lui shift waits for execute
  assign dec_imm = dec_ctrl.signext ? {{16{ifid_q.instr[15]}}, ifid_q.instr[15:0]}
                                    : {16'b0, ifid_q.instr[15:0]};

  always_comb
  begin
    idex_d.ctrl    = dec_ctrl;
    idex_d.pcplus4 = ifid_q.pcplus4;
    idex_d.rs_val  = fwd_dec_a ? wb_result : rf_rd1;   // same cycle writeback
    idex_d.rt_val  = fwd_dec_b ? wb_result : rf_rd2;
    idex_d.imm     = dec_imm;
    idex_d.rs      = ifid_q.instr[25:21];
    idex_d.rt      = ifid_q.instr[20:16];
    idex_d.rd      = ifid_q.instr[15:11];
    idex_d.jidx    = ifid_q.instr[25:0];
  end

  // stall or flush turns the decode slot into a bubble
  pipe_reg #(.payload_t(mips_pkg::idex_t)) u_idex (
    .clk (clk), .reset (reset), .en (1'b1), .clear (flush || stall), .d (idex_d), .q (idex_q)
  );

  hazard_unit u_hz (
    .ifid_rs        (ifid_q.instr[25:21]),
    .ifid_rt        (ifid_q.instr[20:16]),
    .idex_rs        (idex_q.rs),
    .idex_rt        (idex_q.rt),
    .exmem_wreg     (exmem_q.wreg),
    .memwb_wreg     (memwb_q.wreg),
    .idex_memread   (idex_q.ctrl.memread),
    .exmem_regwrite (exmem_q.regwrite),
    .memwb_regwrite (memwb_q.regwrite),
    .redirect       (redirect),
    .stall          (stall),
    .flush          (flush),
    .fwd_dec_a      (fwd_dec_a),
    .fwd_dec_b      (fwd_dec_b),
    .fwd_ex_a       (fwd_ex_a),
    .fwd_ex_b       (fwd_ex_b)
  );

  // --------------------
  // execute
  always_comb
  begin
    case (fwd_ex_a)
      mips_pkg::fwd_mem: ex_a_fwd = exmem_q.alu_result;
      mips_pkg::fwd_wb:  ex_a_fwd = wb_result;
      default:           ex_a_fwd = idex_q.rs_val;
    endcase
    case (fwd_ex_b)
      mips_pkg::fwd_mem: ex_b_fwd = exmem_q.alu_result;
      mips_pkg::fwd_wb:  ex_b_fwd = wb_result;
      default:           ex_b_fwd = idex_q.rt_val;
    endcase
  end

  assign ex_imm = idex_q.ctrl.shiftl16 ? {idex_q.imm[15:0], 16'b0} : idex_q.imm;
  assign alu_a  = idex_q.ctrl.shiftl16 ? '0 : ex_a_fwd;   // lui ignores rs
  assign alu_b  = idex_q.ctrl.alusrc ? ex_imm : ex_b_fwd;

  alu u_alu (.a (alu_a), .b (alu_b), .op (idex_q.ctrl.alucontrol), .result (alu_result),
             .zero (alu_zero));

  // branch and jump targets, both relative to the idex pc+4
  assign branch_target = idex_q.pcplus4 + {idex_q.imm[29:0], 2'b00};
  assign jump_target   = {idex_q.pcplus4[31:28], idex_q.jidx, 2'b00};
  assign pc_target     = idex_q.ctrl.jump ? jump_target : branch_target;
  assign redirect      = idex_q.ctrl.jump || (idex_q.ctrl.branch && alu_zero) ||
                         (idex_q.ctrl.bnebeq && !alu_zero);

  always_comb
  begin
    exmem_d.memread    = idex_q.ctrl.memread;
    exmem_d.memwrite   = idex_q.ctrl.memwrite;
    exmem_d.memtoreg   = idex_q.ctrl.memtoreg;
    exmem_d.regwrite   = idex_q.ctrl.regwrite;
    exmem_d.alu_result = alu_result;
    exmem_d.wdata      = ex_b_fwd;                             // store data after forwarding
    exmem_d.wreg       = idex_q.ctrl.regdst ? idex_q.rd : idex_q.rt;
  end

  pipe_reg #(.payload_t(mips_pkg::exmem_t)) u_exmem (
    .clk (clk), .reset (reset), .en (1'b1), .clear (1'b0), .d (exmem_d), .q (exmem_q)
  );

  // --------------------
  // memory and writeback
  assign mem_write = exmem_q.memwrite;
  assign mem_addr  = exmem_q.alu_result;
  assign mem_wdata = exmem_q.wdata;

  always_comb
  begin
    memwb_d.memtoreg   = exmem_q.memtoreg;
    memwb_d.regwrite   = exmem_q.regwrite;
    memwb_d.rdata      = exmem_q.memread ? mem_rdata : '0;   // only loads capture data
    memwb_d.alu_result = exmem_q.alu_result;
    memwb_d.wreg       = exmem_q.wreg;
  end

  pipe_reg #(.payload_t(mips_pkg::memwb_t)) u_memwb (
    .clk (clk), .reset (reset), .en (1'b1), .clear (1'b0), .d (memwb_d), .q (memwb_q)
  );

  assign wb_result = memwb_q.memtoreg ? memwb_q.rdata : memwb_q.alu_result;

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

// forwarding selects, load use stall and redirect flush
module hazard_unit (
  input  mips_pkg::reg_addr_t ifid_rs,
  input  mips_pkg::reg_addr_t ifid_rt,
  input  mips_pkg::reg_addr_t idex_rs,
  input  mips_pkg::reg_addr_t idex_rt,
  input  mips_pkg::reg_addr_t exmem_wreg,
  input  mips_pkg::reg_addr_t memwb_wreg,
  input  logic                idex_memread,
  input  logic                exmem_regwrite,
  input  logic                memwb_regwrite,
  input  logic                redirect,    // taken branch or jump in execute
  output logic                stall,
  output logic                flush,
  output logic                fwd_dec_a,   // writeback result into decode rs
  output logic                fwd_dec_b,   // and into decode rt
  output mips_pkg::fwd_sel_t  fwd_ex_a,
  output mips_pkg::fwd_sel_t  fwd_ex_b
);

  // a pending write to src that is not r0
  function automatic logic hit(input logic we,
                               input mips_pkg::reg_addr_t wreg,
                               input mips_pkg::reg_addr_t src);
    return we && (wreg != '0) && (wreg == src);
  endfunction

  // --------------------
  // execute operands, newest value first
  always_comb
  begin
    if (hit(exmem_regwrite, exmem_wreg, idex_rs))
      fwd_ex_a = mips_pkg::fwd_mem;
    else if (hit(memwb_regwrite, memwb_wreg, idex_rs))
      fwd_ex_a = mips_pkg::fwd_wb;
    else
      fwd_ex_a = mips_pkg::fwd_none;

    if (hit(exmem_regwrite, exmem_wreg, idex_rt))
      fwd_ex_b = mips_pkg::fwd_mem;
    else if (hit(memwb_regwrite, memwb_wreg, idex_rt))
      fwd_ex_b = mips_pkg::fwd_wb;
    else
      fwd_ex_b = mips_pkg::fwd_none;
  end

  // decode reads bypass the regfile write of this cycle
  assign fwd_dec_a = hit(memwb_regwrite, memwb_wreg, ifid_rs);
  assign fwd_dec_b = hit(memwb_regwrite, memwb_wreg, ifid_rt);

  // --------------------
  // load in execute feeding the decode instruction, one bubble
  assign stall = idex_memread && (idex_rt != '0) &&
                 ((idex_rt == ifid_rs) || (idex_rt == ifid_rt));
  assign flush = redirect;   // kills ifid and idex

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

// five stage pipelined mips core
// instruction and data memories live outside
module mips_core (
  input  logic            clk,
  input  logic            reset,
  // instruction side
  output mips_pkg::word_t pc,         // fetch address
  input  mips_pkg::word_t instr,      // combinational read of pc
  // data side, driven from the memory stage
  output logic            mem_write,  // store strobe
  output mips_pkg::word_t mem_addr,
  output mips_pkg::word_t mem_wdata,
  input  mips_pkg::word_t mem_rdata   // combinational read of mem_addr
);

  // --------------------
  // internal bus toward the pipeline

  mips_pkg::word_t dp_pc;
  mips_pkg::word_t dp_mem_addr;
  mips_pkg::word_t dp_mem_wdata;
  logic            dp_mem_write;

  // pipeline with control, hazards, regfile and alu inside
  datapath u_dp (
    .clk       (clk),
    .reset     (reset),
    .pc        (dp_pc),
    .instr     (instr),
    .mem_write (dp_mem_write),
    .mem_addr  (dp_mem_addr),
    .mem_wdata (dp_mem_wdata),
    .mem_rdata (mem_rdata)
  );

  // --------------------
  // outputs to the memories

  assign pc        = dp_pc;
  assign mem_write = dp_mem_write;   // low after reset since exmem is a bubble
  assign mem_addr  = dp_mem_addr;    // alu result of lw or sw
  assign mem_wdata = dp_mem_wdata;   // forwarded rt value

endmodule

/* source/mips_pkg.sv */
package mips_pkg;

  // --------------------
  // basic widths
  typedef logic [31:0] word_t;      // data and address word
  typedef logic [4:0]  reg_addr_t;  // register index

  localparam word_t pc_step = 32'd4;  // byte step between instructions

  // --------------------
  // opcodes, instr[31:26]
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_beq   = 6'b000100;
  localparam logic [5:0] op_bne   = 6'b000101;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_addiu = 6'b001001;
  localparam logic [5:0] op_ori   = 6'b001101;
  localparam logic [5:0] op_lui   = 6'b001111;
  localparam logic [5:0] op_j     = 6'b000010;
  localparam logic [5:0] op_slti  = 6'b001010;

  // funct codes for r-type, instr[5:0]
  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;  // no overflow trap, same as add here
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_slt  = 6'b101010;
  localparam logic [5:0] fn_sltu = 6'b101011;

  // alu operation codes
  typedef enum logic [3:0] {
    alu_and  = 4'b0000,
    alu_or   = 4'b0001,
    alu_add  = 4'b0010,
    alu_sub  = 4'b0110,
    alu_slt  = 4'b0111,
    alu_sltu = 4'b1111   // unsigned compare
  } alu_ctrl_t;

  // execute stage operand source
  typedef enum logic [1:0] {
    fwd_none = 2'b00,    // value read in decode
    fwd_wb   = 2'b01,
    fwd_mem  = 2'b10
  } fwd_sel_t;

  // --------------------
  // decoded controls, all zero is a bubble
  typedef struct packed {
    logic      signext;   // sign extend the immediate
    logic      shiftl16;  // lui
    logic      regdst;    // write rd instead of rt
    logic      alusrc;    // immediate as alu operand b
    logic      branch;    // beq
    logic      bnebeq;    // bne
    logic      jump;
    logic      memread;
    logic      memwrite;
    logic      memtoreg;
    logic      regwrite;
    alu_ctrl_t alucontrol;
  } ctrl_t;

  // stage registers
  typedef struct packed {
    word_t instr;
    word_t pcplus4;
  } ifid_t;

  typedef struct packed {
    ctrl_t       ctrl;
    word_t       pcplus4;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm;       // already extended
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [25:0] jidx;      // jump index
  } idex_t;

  typedef struct packed {
    logic      memread;
    logic      memwrite;
    logic      memtoreg;
    logic      regwrite;
    word_t     alu_result;
    word_t     wdata;       // store data
    reg_addr_t wreg;
  } exmem_t;

  typedef struct packed {
    logic      memtoreg;
    logic      regwrite;
    word_t     rdata;
    word_t     alu_result;
    reg_addr_t wreg;
  } memwb_t;

endpackage

/* source/pipe_reg.sv */
`timescale 1ns/1ps

// one stage register for any stage struct
// all zero is a bubble for every payload
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     en,      // low holds the current contents
  input  logic     clear,   // inserts a bubble, wins over en
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      q <= '0;
    end
    else if (en)
    begin
      q <= d;
    end
  end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

// 32 x 32 register file
// two async read ports, one write port on the clock edge
module regfile (
  input  logic                clk,
  input  logic                we,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::reg_addr_t wa,
  input  mips_pkg::word_t     wd,
  output mips_pkg::word_t     rd1,
  output mips_pkg::word_t     rd2
);

  mips_pkg::word_t regs [0:31];

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      regs[wa] <= wd;
    end
  end

  // r0 is hardwired, whatever was written there
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* verification/mips_model.svh */
`ifndef mips_model_svh
`define mips_model_svh

// isa reference model, no delay slot
// runs imem from address 0 until it reaches the jump to itself
mips_pkg::word_t m_regs [0:31];
mips_pkg::word_t m_dmem [0:63];
mips_pkg::word_t exp_addr [$];   // expected store stream, oldest first
mips_pkg::word_t exp_data [$];

task automatic interpret_program();
  mips_pkg::word_t mpc, ins, a, b, sx, zx, res, addr, tgt;
  logic [5:0]      op;
  logic [4:0]      dst;
  logic            wr;
  int              steps;
  mpc   = '0;
  steps = 0;
  exp_addr.delete();
  exp_data.delete();
  for (int i = 0; i < 32; i++)
    m_regs[i] = '0;
  for (int i = 0; i < 64; i++)
    m_dmem[i] = data_pattern(i);
  while (1)
  begin
    ins   = imem[mpc[9:2]];
    op    = ins[31:26];
    a     = m_regs[ins[25:21]];
    b     = m_regs[ins[20:16]];
    sx    = {{16{ins[15]}}, ins[15:0]};   // sign extended
    zx    = {16'b0, ins[15:0]};           // zero extended, ori only
    dst   = ins[20:16];                   // rt unless r-type
    wr    = 1'b1;
    res   = '0;
    steps = steps + 1;
    if (steps > 1000)
      stop_with_failure("reference model never reached the end of the program");
    mpc = mpc + 32'd4;
    case (op)
      mips_pkg::op_rtype:
      begin
        dst = ins[15:11];
        case (ins[5:0])
          mips_pkg::fn_add, mips_pkg::fn_addu: res = a + b;   // no overflow trap
          mips_pkg::fn_sub, mips_pkg::fn_subu: res = a - b;
          mips_pkg::fn_and:  res = a & b;
          mips_pkg::fn_or:   res = a | b;
          mips_pkg::fn_slt:  res = {31'b0, ($signed(a) < $signed(b))};
          mips_pkg::fn_sltu: res = {31'b0, (a < b)};
          default:           wr = 1'b0;
        endcase
      end
      mips_pkg::op_addi, mips_pkg::op_addiu: res = a + sx;
      mips_pkg::op_slti: res = {31'b0, ($signed(a) < $signed(sx))};
      mips_pkg::op_ori:  res = a | zx;
      mips_pkg::op_lui:  res = {ins[15:0], 16'b0};
      mips_pkg::op_lw:
      begin
        addr = a + sx;
        res  = m_dmem[addr[7:2]];
      end
      mips_pkg::op_sw:
      begin
        addr = a + sx;
        wr   = 1'b0;
        m_dmem[addr[7:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      mips_pkg::op_beq, mips_pkg::op_bne:
      begin
        wr = 1'b0;
        if ((a == b) == (op == mips_pkg::op_beq))
          mpc = mpc + {sx[29:0], 2'b00};   // relative to pc+4
      end
      mips_pkg::op_j:
      begin
        wr  = 1'b0;
        tgt = {mpc[31:28], ins[25:0], 2'b00};
        if (tgt == mpc - 32'd4)
          return;                          // endless loop marks the end
        mpc = tgt;
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0)
      m_regs[dst] = res;                   // r0 stays zero
  end
endtask

`endif

/* verification/tb_mips.sv */
`timescale 1ns/1ps

// testbench for the pipelined mips core
// random programs run on the DUT and on an isa model, store streams compared
module tb_mips;

  logic            clk;
  logic            reset;
  logic            mem_write;
  mips_pkg::word_t pc, instr, mem_addr, mem_wdata, mem_rdata;

  mips_pkg::word_t imem [0:255];
  mips_pkg::word_t dmem [0:63] = '{default: '0};

  integer seed = 32'hd13f;
  logic   running;      // monitor and watchdog armed
  int     seen;         // stores observed in this program
  int     wd_cycles;
  int     wd_limit;
  int     prog_id;
  int     prog_len;     // instructions incl the final jump

  logic [5:0] fn_tab [0:7] = '{mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
                               mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                               mips_pkg::fn_slt, mips_pkg::fn_sltu};
  logic [5:0] imm_tab [0:4] = '{mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_ori,
                                mips_pkg::op_lui, mips_pkg::op_slti};

  mips_core UUT (
    .clk (clk), .reset (reset), .pc (pc), .instr (instr), .mem_write (mem_write),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
  );

  always #20 clk = ~clk;   // 40 ns period

  // --------------------
  // memories, both read combinationally
  assign instr     = imem[pc[9:2]];
  assign mem_rdata = dmem[mem_addr[7:2]];

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 64; i++)
        dmem[i] <= data_pattern(i);          // fresh contents for every program
    end
    else if (mem_write)
      dmem[mem_addr[7:2]] <= mem_wdata;
  end

  // --------------------
  // helpers
  function automatic mips_pkg::word_t data_pattern(input int i);
    return 32'h1357_0000 ^ (32'(i) * 32'h0101_0033);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic mips_pkg::word_t r_type(input logic [5:0] fn,
                                             input mips_pkg::reg_addr_t rs, rt, rd);
    return {mips_pkg::op_rtype, rs, rt, rd, 5'b0, fn};
  endfunction

  function automatic mips_pkg::word_t i_type(input logic [5:0] op,
                                             input mips_pkg::reg_addr_t rs, rt,
                                             input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic mips_pkg::word_t j_type(input int word_index);
    return {mips_pkg::op_j, 26'(word_index)};
  endfunction

  // words past the program are stores, so a wrong fetch shows on the bus
  function automatic mips_pkg::word_t unused_slot(input int i);
    return i_type(mips_pkg::op_sw, 5'd0, 5'(i), 16'(4 * i));
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input mips_pkg::word_t expected,
                       input mips_pkg::word_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
  endtask

  `include "mips_model.svh"

  // --------------------
  // program generation
  // mode 0 alu only, 1 adds loads and chains, 2 adds branches and jumps
  task automatic gen_program(input int mode, input int items);
    mips_pkg::reg_addr_t rs, rt, rd, last;
    logic [15:0]         imm;
    int                  n, c, skip;
    n    = 0;
    last = 5'd1;
    for (int i = 0; i < 256; i++)
      imem[i] = unused_slot(i);
    for (int r = 1; r < 32; r++)
    begin
      imem[n] = i_type(mips_pkg::op_addiu, 5'd0, 5'(r), 16'(rand_below(65536)));
      n++;
    end
    for (int k = 0; k < items; k++)
    begin
      rs  = 5'(rand_below(32));
      rt  = 5'(rand_below(32));
      rd  = 5'(rand_below(32));              // r0 as target now and then
      imm = 16'(rand_below(65536));
      c   = rand_below(10 + 4 * mode);
      if (mode > 0 && rand_below(2) == 1)
        rs = last;                           // back to back dependency
      if (c < 5)
      begin
        imem[n] = r_type(fn_tab[rand_below(8)], rs, rt, rd);
        last = rd;
        n = n + 1;
      end
      else if (c < 9)
      begin
        imem[n] = i_type(imm_tab[rand_below(5)], rs, rt, imm);
        last = rt;
        n = n + 1;
      end
      else if (c == 9)
      begin
        imem[n] = i_type(mips_pkg::op_sw, 5'd0, rt, 16'(4 * rand_below(32)));
        n = n + 1;
      end
      else if (c < 12)
      begin
        // load then immediate use, one bubble
        imem[n]     = i_type(mips_pkg::op_lw, 5'd0, rt, 16'(4 * rand_below(64)));
        imem[n + 1] = r_type(fn_tab[rand_below(8)], rt, rs, rd);
        last = rd;
        n = n + 2;
      end
      else if (c < 14)
      begin
        // rt used 1, 2 and 3 slots later: mem, wb and decode forwarding
        imem[n]     = i_type(mips_pkg::op_addiu, rs, rt, imm);
        imem[n + 1] = r_type(fn_tab[rand_below(8)], rt, rs, rd);
        imem[n + 2] = i_type(mips_pkg::op_sw, 5'd0, rt, 16'(4 * rand_below(32)));
        imem[n + 3] = r_type(fn_tab[rand_below(8)], rd, rt, rs);
        last = rs;
        n = n + 4;
      end
      else
      begin
        skip = 2 + rand_below(2);            // slots jumped over
        if (rand_below(2) == 1)
          rt = rs;                           // equal operands
        case (rand_below(3))
          0:       imem[n] = i_type(mips_pkg::op_beq, rs, rt, 16'(skip));
          1:       imem[n] = i_type(mips_pkg::op_bne, rs, rt, 16'(skip));
          default: imem[n] = j_type(n + 1 + skip);
        endcase
        for (int s = 1; s <= skip; s++)
          imem[n + s] = i_type(mips_pkg::op_sw, 5'd0, 5'(rand_below(32)),
                               16'(4 * rand_below(32)));
        n = n + 1 + skip;
      end
    end
    for (int r = 0; r < 32; r++)
    begin
      imem[n] = i_type(mips_pkg::op_sw, 5'd0, 5'(r), 16'(128 + 4 * r));  // register dump
      n = n + 1;
    end
    imem[n]  = j_type(n);                    // parks the core
    prog_len = n + 1;
  endtask

  // --------------------
  // one program: reset, pc check, then wait for the whole store stream
  task automatic run_program(input int mode, input int items);
    @(posedge clk);
    #1;
    running = 1'b0;
    reset   = 1'b1;
    gen_program(mode, items);
    interpret_program();
    wd_limit = 4 * prog_len + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check($sformatf("prog %0d pc in reset", prog_id), 32'd0, pc);
    check($sformatf("prog %0d mem_write in reset", prog_id), 32'd0, {31'b0, mem_write});
    @(posedge clk);
    #1;
    reset   = 1'b0;
    running = 1'b1;
    for (int k = 0; k < 8; k++)
    begin
      @(negedge clk);
      check($sformatf("prog %0d pc step %0d", prog_id, k), 32'(4 * k), pc);
      if (k < 3)
        check($sformatf("prog %0d early store", prog_id), 32'd0, {31'b0, mem_write});
    end
    while (seen < exp_addr.size())
      @(posedge clk);
    repeat (12) @(posedge clk);              // a late extra store would show here
    prog_id = prog_id + 1;
  endtask

  // store monitor, outputs settled by the falling edge
  always @(negedge clk)
  begin
    if (!running)
      seen = 0;
    else if (mem_write)
    begin
      if (seen >= exp_addr.size())
        stop_with_failure($sformatf("program %0d made a store the model never made", prog_id));
      check($sformatf("prog %0d store %0d addr", prog_id, seen), exp_addr[seen], mem_addr);
      check($sformatf("prog %0d store %0d data", prog_id, seen), exp_data[seen], mem_wdata);
      seen = seen + 1;
    end
  end

  // watchdog, budget scales with program length
  always @(posedge clk)
  begin
    if (!running)
      wd_cycles = 0;
    else
    begin
      wd_cycles = wd_cycles + 1;
      if (wd_cycles > wd_limit)
        stop_with_failure($sformatf("program %0d did not finish within %0d cycles",
                                    prog_id, wd_limit));
    end
  end

  initial
  begin
    clk      = 1'b0;
    reset    = 1'b1;
    running  = 1'b0;
    wd_limit = 0;
    prog_id  = 0;
    for (int i = 0; i < 256; i++)
      imem[i] = unused_slot(i);
    for (int p = 0; p < 12; p++)
      run_program(p % 3, 40);                // modes cycle alu, loads, redirects
    $display("Test completed successfully");
    $finish;
  end

endmodule
